//--- Bender.yml
package:
  name: bitstream_unpack

sources:
  # Packages first, then the blocks, then the top level
  - target: any(design, test)
    files:
      - design/codec_pkg.sv
      - design/mem_pkg.sv
      - design/scratch_mem.sv
      - design/field_dispatch.sv
      - design/bits_to_int.sv
      - design/param_collect.sv
      - design/bitstream_unpack_top.sv

  - target: test
    files:
      - tests/clk_gen.sv
      - tests/tb_bitstream_unpack.sv

//--- bitstream_unpack_top.f
design/codec_pkg.sv
design/mem_pkg.sv
design/scratch_mem.sv
design/field_dispatch.sv
design/bits_to_int.sv
design/param_collect.sv
design/bitstream_unpack_top.sv
tests/clk_gen.sv
tests/tb_bitstream_unpack.sv

//--- design/bits_to_int.sv
`timescale 1ns/10ps

module bits_to_int (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         start,
	input  logic [codec_pkg::VALUE_W-1:0] bitsno,
	input  logic [mem_pkg::OFFSET_W-1:0]  offset,
	output logic                         done,
	output logic [codec_pkg::VALUE_W-1:0] value,
	output logic [mem_pkg::ADDR_W-1:0]    rd_addr,
	input  logic [mem_pkg::DATA_W-1:0]    rd_data
);

	typedef enum logic [2:0] {
		IDLE,
		READ,
		FETCH,
		ACCUM,
		FINISH
	} state_t;

	state_t                        state, next_state;
	logic [codec_pkg::VALUE_W-1:0] count, next_count;
	logic [mem_pkg::OFFSET_W-1:0]  bit_addr, next_bit_addr;
	logic [mem_pkg::DATA_W-1:0]    bit_reg, next_bit_reg;
	logic [codec_pkg::VALUE_W-1:0] next_value;
	logic [codec_pkg::VALUE_W-1:0] shifted;
	logic                          next_done;

	// The current bit word sits in the serial region
	assign rd_addr = {mem_pkg::SERIAL_BASE, bit_addr};
	assign shifted = value << 1;

	//////////////////////////////////////////////////////////////
	// Next state
	//////////////////////////////////////////////////////////////

	always_comb begin
		next_state    = state;
		next_count    = count;
		next_bit_addr = bit_addr;
		next_bit_reg  = bit_reg;
		next_value    = value;
		next_done     = 1'b0;
		case (state)
			IDLE: begin
				if (start) begin
					next_state    = READ;
					next_count    = '0;
					next_bit_addr = offset;
					next_value    = '0;
				end
			end
			READ: begin
				if (count == bitsno) begin
					next_state = FINISH;
					next_done  = 1'b1;
				end else begin
					// Address is on rd_addr this cycle
					next_bit_addr = bit_addr + 1'b1;
					next_state    = FETCH;
				end
			end
			FETCH: begin
				next_bit_reg = rd_data;
				next_count   = count + 1'b1;
				next_state   = ACCUM;
			end
			ACCUM: begin
				// MSB first
				if (bit_reg == codec_pkg::BIT_ONE) begin
					next_value = shifted + 1'b1;
				end else begin
					next_value = shifted;
				end
				next_state = READ;
			end
			FINISH: begin
				next_state = IDLE;
			end
			default: begin
				next_state = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			count <= '0;
			done  <= 1'b0;
		end else begin
			state <= next_state;
			count <= next_count;
			done  <= next_done;
		end
	end

	always_ff @(posedge clk) begin
		bit_addr <= next_bit_addr;
		bit_reg  <= next_bit_reg;
		value    <= next_value;
	end

endmodule

//--- design/bitstream_unpack_top.sv
`timescale 1ns/10ps

module bitstream_unpack_top #(
	parameter int NUM_UNITS = 4
) (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              load_en,
	input  logic [mem_pkg::OFFSET_W-1:0]      load_addr,
	input  logic [mem_pkg::DATA_W-1:0]        load_data,
	input  logic                              frame_start,
	output logic                              busy,
	output logic                              param_valid,
	output logic [codec_pkg::FIELD_IDX_W-1:0] param_index,
	output logic [codec_pkg::VALUE_W-1:0]     param_value,
	output logic                              frame_done
);

	logic [NUM_UNITS-1:0]              unit_start;
	logic [NUM_UNITS-1:0]              unit_done;
	logic [codec_pkg::VALUE_W-1:0]     unit_bitsno [NUM_UNITS];
	logic [mem_pkg::OFFSET_W-1:0]      unit_offset [NUM_UNITS];
	logic [codec_pkg::FIELD_IDX_W-1:0] unit_tag [NUM_UNITS];
	logic [codec_pkg::VALUE_W-1:0]     unit_value [NUM_UNITS];
	logic [mem_pkg::ADDR_W-1:0]        rd_addr [NUM_UNITS];
	logic [mem_pkg::DATA_W-1:0]        rd_data [NUM_UNITS];

	scratch_mem #(.NUM_UNITS(NUM_UNITS)) u_mem (
		.clk     (clk),
		.wr_en   (load_en),
		.wr_addr (load_addr),
		.wr_data (load_data),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	field_dispatch #(.NUM_UNITS(NUM_UNITS)) u_dispatch (
		.clk         (clk),
		.reset       (reset),
		.frame_start (frame_start),
		.frame_done  (frame_done),
		.done        (unit_done),
		.busy        (busy),
		.unit_start  (unit_start),
		.unit_bitsno (unit_bitsno),
		.unit_offset (unit_offset),
		.unit_tag    (unit_tag)
	);

	// Pool of identical converters
	for (genvar k = 0; k < NUM_UNITS; k++) begin : g_unit
		bits_to_int u_unit (
			.clk     (clk),
			.reset   (reset),
			.start   (unit_start[k]),
			.bitsno  (unit_bitsno[k]),
			.offset  (unit_offset[k]),
			.done    (unit_done[k]),
			.value   (unit_value[k]),
			.rd_addr (rd_addr[k]),
			.rd_data (rd_data[k])
		);
	end

	param_collect #(.NUM_UNITS(NUM_UNITS)) u_collect (
		.clk         (clk),
		.reset       (reset),
		.done        (unit_done),
		.value       (unit_value),
		.tag         (unit_tag),
		.param_valid (param_valid),
		.param_index (param_index),
		.param_value (param_value),
		.frame_done  (frame_done)
	);

endmodule

//--- design/codec_pkg.sv
package codec_pkg;

	//////////////////////////////////////////////////////////////
	// Frame layout
	//////////////////////////////////////////////////////////////

	// Parameters carried by one frame
	localparam int NUM_FIELDS = 11;

	// Tag that travels with a field through the units
	localparam int FIELD_IDX_W = 4;

	// Width of an unpacked parameter and of a bit count
	localparam int VALUE_W = 16;

	// Bit width of each field in stream order
	//  0  first LSP index
	//  1  second LSP index
	//  2  pitch delay, first subframe
	//  3  pitch delay check bit
	//  4  fixed codebook index, first subframe
	//  5  fixed codebook signs, first subframe
	//  6  gain index, first subframe
	//  7  pitch delay, second subframe
	//  8  fixed codebook index, second subframe
	//  9  fixed codebook signs, second subframe
	// 10  gain index, second subframe
	localparam int FIELD_WIDTHS [NUM_FIELDS] = '{
		8, 10, 8, 1, 13, 4, 7, 5, 13, 4, 7
	};

	// Sum of the table above
	localparam int FRAME_BITS = 80;

	//////////////////////////////////////////////////////////////
	// Bit-word codes
	//////////////////////////////////////////////////////////////

	// One serial bit is stored as a whole 16-bit word
	localparam logic [15:0] BIT_ONE  = 16'h0081;

	// Usual code for a zero; any word other than BIT_ONE reads as zero
	localparam logic [15:0] BIT_ZERO = 16'h007f;

endpackage

//--- design/field_dispatch.sv
`timescale 1ns/10ps

module field_dispatch #(
	parameter int NUM_UNITS = 4
) (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           frame_start,
	input  logic                           frame_done,
	input  logic [NUM_UNITS-1:0]           done,
	output logic                           busy,
	output logic [NUM_UNITS-1:0]           unit_start,
	output logic [codec_pkg::VALUE_W-1:0]     unit_bitsno [NUM_UNITS],
	output logic [mem_pkg::OFFSET_W-1:0]      unit_offset [NUM_UNITS],
	output logic [codec_pkg::FIELD_IDX_W-1:0] unit_tag [NUM_UNITS]
);

	localparam logic [codec_pkg::FIELD_IDX_W-1:0] END_IDX =
		codec_pkg::FIELD_IDX_W'(codec_pkg::NUM_FIELDS);

	logic [NUM_UNITS-1:0]              free_mask;
	logic [NUM_UNITS-1:0]              grant;
	logic [NUM_UNITS-1:0]              taken;
	logic [codec_pkg::FIELD_IDX_W-1:0] field_idx;
	logic [mem_pkg::OFFSET_W-1:0]      bit_off;
	logic [codec_pkg::VALUE_W-1:0]     field_width;
	logic                              issue;

	// Lowest set bit of the free mask
	assign grant = free_mask & (~free_mask + 1'b1);

	assign issue = busy && (field_idx != END_IDX) && (|free_mask);
	assign taken = issue ? grant : '0;

	always_comb begin
		field_width = '0;
		if (field_idx < END_IDX) begin
			field_width = codec_pkg::VALUE_W'(codec_pkg::FIELD_WIDTHS[field_idx]);
		end
	end

	//////////////////////////////////////////////////////////////
	// Frame walk and unit tracking
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			busy       <= 1'b0;
			field_idx  <= '0;
			bit_off    <= '0;
			free_mask  <= '1;
			unit_start <= '0;
		end else begin
			unit_start <= taken;
			// A unit is never done and granted in the same cycle
			free_mask  <= (free_mask & ~taken) | done;
			if (frame_start && !busy) begin
				busy      <= 1'b1;
				field_idx <= '0;
				bit_off   <= '0;
			end else begin
				if (frame_done) begin
					busy <= 1'b0;
				end
				if (issue) begin
					field_idx <= field_idx + 1'b1;
					bit_off   <= bit_off + mem_pkg::OFFSET_W'(field_width);
				end
			end
		end
	end

	// Field descriptor held at the granted unit until its next start
	always_ff @(posedge clk) begin
		for (int k = 0; k < NUM_UNITS; k++) begin
			if (taken[k]) begin
				unit_bitsno[k] <= field_width;
				unit_offset[k] <= bit_off;
				unit_tag[k]    <= field_idx;
			end
		end
	end

endmodule

//--- design/mem_pkg.sv
package mem_pkg;

	// Scratch memory word and address size
	localparam int ADDR_W = 12;
	localparam int DATA_W = 16;

	// Offset of a word inside the serial region
	localparam int OFFSET_W = 7;

	// Upper address bits that select the serial region
	localparam logic [ADDR_W-OFFSET_W-1:0] SERIAL_BASE = 5'h1a;

endpackage

//--- design/param_collect.sv
`timescale 1ns/10ps

module param_collect #(
	parameter int NUM_UNITS = 4
) (
	input  logic                              clk,
	input  logic                              reset,
	input  logic [NUM_UNITS-1:0]              done,
	input  logic [codec_pkg::VALUE_W-1:0]     value [NUM_UNITS],
	input  logic [codec_pkg::FIELD_IDX_W-1:0] tag [NUM_UNITS],
	output logic                              param_valid,
	output logic [codec_pkg::FIELD_IDX_W-1:0] param_index,
	output logic [codec_pkg::VALUE_W-1:0]     param_value,
	output logic                              frame_done
);

	localparam logic [codec_pkg::FIELD_IDX_W-1:0] LAST_IDX =
		codec_pkg::FIELD_IDX_W'(codec_pkg::NUM_FIELDS - 1);

	logic [codec_pkg::VALUE_W-1:0]     vals [codec_pkg::NUM_FIELDS];
	logic [codec_pkg::NUM_FIELDS-1:0]  filled;
	logic [codec_pkg::FIELD_IDX_W-1:0] out_idx;
	logic                              streaming;
	logic                              last_issue;
	logic                              last_beat;

	assign last_issue = streaming && (out_idx == LAST_IDX);

	//////////////////////////////////////////////////////////////
	// Fill tracking and output sequencing
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			filled      <= '0;
			streaming   <= 1'b0;
			out_idx     <= '0;
			param_valid <= 1'b0;
			last_beat   <= 1'b0;
			frame_done  <= 1'b0;
		end else begin
			param_valid <= streaming;
			last_beat   <= last_issue;
			frame_done  <= last_beat;
			if (last_issue) begin
				filled <= '0;
			end else begin
				for (int k = 0; k < NUM_UNITS; k++) begin
					if (done[k]) begin
						filled[tag[k]] <= 1'b1;
					end
				end
			end
			if (streaming) begin
				out_idx <= out_idx + 1'b1;
				if (last_issue) begin
					streaming <= 1'b0;
				end
			end else if (&filled) begin
				streaming <= 1'b1;
				out_idx   <= '0;
			end
		end
	end

	// Values land by tag, in whatever order the units finish
	always_ff @(posedge clk) begin
		for (int k = 0; k < NUM_UNITS; k++) begin
			if (done[k]) begin
				vals[tag[k]] <= value[k];
			end
		end
		if (streaming) begin
			param_index <= out_idx;
			param_value <= vals[out_idx];
		end
	end

endmodule

//--- design/scratch_mem.sv
`timescale 1ns/10ps

module scratch_mem #(
	parameter int NUM_UNITS = 4
) (
	input  logic                        clk,
	input  logic                        wr_en,
	input  logic [mem_pkg::OFFSET_W-1:0] wr_addr,
	input  logic [mem_pkg::DATA_W-1:0]   wr_data,
	input  logic [mem_pkg::ADDR_W-1:0]   rd_addr [NUM_UNITS],
	output logic [mem_pkg::DATA_W-1:0]   rd_data [NUM_UNITS]
);

	localparam int DEPTH = 1 << mem_pkg::ADDR_W;

	logic [mem_pkg::DATA_W-1:0] mem [DEPTH];
	logic [mem_pkg::ADDR_W-1:0] wr_full_addr;

	// Loads only land in the serial region
	assign wr_full_addr = {mem_pkg::SERIAL_BASE, wr_addr};

	//////////////////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_full_addr] <= wr_data;
		end
	end

	//////////////////////////////////////////////////////////////
	// Read ports, one per unit
	//////////////////////////////////////////////////////////////

	// Every port registers its word each cycle, so data follows
	// the address by exactly one clock
	always_ff @(posedge clk) begin
		for (int k = 0; k < NUM_UNITS; k++) begin
			rd_data[k] <= mem[rd_addr[k]];
		end
	end

endmodule

//--- tests/clk_gen.sv
`timescale 1ns/10ps

module clk_gen #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 4
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD_NS / 2) clk = ~clk;
		end
	end

	// Held over the first rising edges, released between edges
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

//--- tests/tb_bitstream_unpack.sv
`timescale 1ns/10ps

module tb_bitstream_unpack;

	localparam int NUM_UNITS   = 4;
	localparam int NUM_FIELDS  = codec_pkg::NUM_FIELDS;
	localparam int FRAME_BITS  = codec_pkg::FRAME_BITS;
	// One frame at most, doubled so a single unit still fits
	localparam int FRAME_LIMIT = 2 * (3 * FRAME_BITS + NUM_FIELDS + 40);
	localparam int IDLE_CHECK  = 20;
	// Ten frames over six tests, each with its load and idle time
	localparam int NUM_FRAMES  = 10;
	localparam int RUN_LIMIT   = NUM_FRAMES * (FRAME_LIMIT + FRAME_BITS + IDLE_CHECK + 10) + 200;

	logic                              clk;
	logic                              reset;
	logic                              load_en;
	logic [mem_pkg::OFFSET_W-1:0]      load_addr;
	logic [mem_pkg::DATA_W-1:0]        load_data;
	logic                              frame_start;
	logic                              busy;
	logic                              param_valid;
	logic [codec_pkg::FIELD_IDX_W-1:0] param_index;
	logic [codec_pkg::VALUE_W-1:0]     param_value;
	logic                              frame_done;

	logic [codec_pkg::VALUE_W-1:0] exp_vals [NUM_FIELDS];
	logic  last_valid = 1'b0;
	int    errors = 0;
	int    checks = 0;
	int    streams_seen = 0;
	int    total_beats = 0;
	int    beat_cnt = 0;
	int    cycle_count = 0;
	int    tests_run = 0;
	int    tests_failed = 0;
	int    test_err_base = 0;
	string test_name;

	clk_gen #(.PERIOD_NS(40), .RESET_CYCLES(4)) u_clk (
		.clk   (clk),
		.reset (reset)
	);

	bitstream_unpack_top #(.NUM_UNITS(NUM_UNITS)) DUT (
		.clk         (clk),
		.reset       (reset),
		.load_en     (load_en),
		.load_addr   (load_addr),
		.load_data   (load_data),
		.frame_start (frame_start),
		.busy        (busy),
		.param_valid (param_valid),
		.param_index (param_index),
		.param_value (param_value),
		.frame_done  (frame_done)
	);

	////////////////////////////////////////////////////////////
	// Reference model and stimulus helpers
	////////////////////////////////////////////////////////////

	// Stream bit i is frame[FRAME_BITS-1-i], fields are MSB first
	function automatic logic [codec_pkg::VALUE_W-1:0] ref_field(
		input logic [FRAME_BITS-1:0] frame,
		input int idx
	);
		int first_bit;
		logic [codec_pkg::VALUE_W-1:0] acc;
		first_bit = 0;
		for (int f = 0; f < idx; f++) begin
			first_bit += codec_pkg::FIELD_WIDTHS[f];
		end
		acc = '0;
		for (int b = 0; b < codec_pkg::FIELD_WIDTHS[idx]; b++) begin
			acc = {acc[codec_pkg::VALUE_W-2:0], frame[FRAME_BITS-1-first_bit-b]};
		end
		return acc;
	endfunction

	function automatic logic [FRAME_BITS-1:0] random_frame();
		logic [FRAME_BITS-1:0] frame;
		frame[31:0]  = $urandom;
		frame[63:32] = $urandom;
		frame[79:64] = 16'($urandom);
		return frame;
	endfunction

	// Any word other than BIT_ONE must read as a zero
	function automatic logic [mem_pkg::DATA_W-1:0] zero_word(input bit mixed);
		logic [mem_pkg::DATA_W-1:0] w;
		w = codec_pkg::BIT_ZERO;
		if (mixed && ($urandom_range(1, 0) == 1)) begin
			w = 16'($urandom);
			if (w == codec_pkg::BIT_ONE) begin
				w = 16'h0000;
			end
		end
		return w;
	endfunction

	task automatic load_frame(input logic [FRAME_BITS-1:0] frame, input bit mixed);
		for (int i = 0; i < FRAME_BITS; i++) begin
			load_en   = 1'b1;
			load_addr = mem_pkg::OFFSET_W'(i);
			load_data = frame[FRAME_BITS-1-i] ? codec_pkg::BIT_ONE : zero_word(mixed);
			@(negedge clk);
		end
		load_en = 1'b0;
	endtask

	task automatic run_frame(
		input logic [FRAME_BITS-1:0] frame,
		input bit mixed,
		input bit extra_start
	);
		int wait_cycles;
		int streams_before;
		int beats_before;
		bit seen_done;
		for (int f = 0; f < NUM_FIELDS; f++) begin
			exp_vals[f] = ref_field(frame, f);
		end
		load_frame(frame, mixed);
		streams_before = streams_seen;
		beats_before   = total_beats;
		frame_start    = 1'b1;
		@(negedge clk);
		frame_start = 1'b0;
		wait_cycles = 0;
		seen_done   = 1'b0;
		while (!seen_done && (wait_cycles < FRAME_LIMIT)) begin
			@(negedge clk);
			wait_cycles++;
			if (frame_done) begin
				seen_done = 1'b1;
			end else begin
				if (busy !== 1'b1) begin
					$display("mismatch busy exp 0x1 got 0x%h", busy);
					errors++;
				end
				// Retrigger attempts while the frame is in flight
				frame_start = extra_start && ((wait_cycles == 3) || (wait_cycles == 30));
			end
		end
		frame_start = 1'b0;
		if (!seen_done) begin
			$display("frame_done did not arrive within %0d cycles", FRAME_LIMIT);
			errors++;
		end else begin
			@(negedge clk);
			if (busy !== 1'b0) begin
				$display("mismatch busy exp 0x0 got 0x%h", busy);
				errors++;
			end
			if (extra_start) begin
				repeat (IDLE_CHECK) begin
					@(negedge clk);
					if (busy !== 1'b0) begin
						$display("mismatch busy exp 0x0 got 0x%h", busy);
						errors++;
					end
				end
			end
			if (streams_seen != streams_before + 1) begin
				$display("expected one output stream but saw %0d", streams_seen - streams_before);
				errors++;
			end
			if (total_beats != beats_before + NUM_FIELDS) begin
				$display("expected %0d output beats but saw %0d", NUM_FIELDS,
					total_beats - beats_before);
				errors++;
			end
		end
	endtask

	task automatic open_test(input string name);
		test_name     = name;
		test_err_base = errors;
		tests_run++;
	endtask

	task automatic close_test();
		if (errors == test_err_base) begin
			$display("test %0d %s: ok", tests_run, test_name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed with %0d errors", tests_run, test_name,
				errors - test_err_base);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Output stream comparison
	////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		if (!reset) begin
			if (param_valid) begin
				if (beat_cnt >= NUM_FIELDS) begin
					$display("more than %0d beats in one stream", NUM_FIELDS);
					errors++;
				end else begin
					checks++;
					if (param_index !== codec_pkg::FIELD_IDX_W'(beat_cnt)) begin
						$display("mismatch param_index exp 0x%h got 0x%h",
							codec_pkg::FIELD_IDX_W'(beat_cnt), param_index);
						errors++;
					end
					if (param_value !== exp_vals[beat_cnt]) begin
						$display("mismatch param_value exp 0x%h got 0x%h",
							exp_vals[beat_cnt], param_value);
						errors++;
					end
				end
				if (busy !== 1'b1) begin
					$display("mismatch busy exp 0x1 got 0x%h", busy);
					errors++;
				end
				beat_cnt++;
				total_beats++;
			end else if ((beat_cnt > 0) && !frame_done) begin
				$display("stream broke off after %0d beats without frame_done", beat_cnt);
				errors++;
				beat_cnt = 0;
			end
			if (frame_done) begin
				if (param_valid || !last_valid || (beat_cnt != NUM_FIELDS)) begin
					$display("frame_done did not directly follow %0d beats", NUM_FIELDS);
					errors++;
				end
				streams_seen++;
				beat_cnt = 0;
			end
			last_valid = param_valid;
		end
	end

	// Run limit from the frame count and the per-frame budget
	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= RUN_LIMIT) begin
			$display("timeout, run stopped after %0d cycles", cycle_count);
			$display("** FAIL **");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		int seed_val;
		seed_val    = $urandom(32'h1186);
		load_en     = 1'b0;
		load_addr   = '0;
		load_data   = '0;
		frame_start = 1'b0;
		wait (reset === 1'b0);
		@(negedge clk);

		open_test("all zero words");
		run_frame('0, 1'b0, 1'b0);
		close_test();

		open_test("all one words");
		run_frame('1, 1'b0, 1'b0);
		close_test();

		open_test("random frames, mixed zero codes");
		repeat (4) begin
			run_frame(random_frame(), 1'b1, 1'b0);
		end
		close_test();

		open_test("stream framing and busy");
		run_frame({5{16'ha5c3}}, 1'b1, 1'b0);
		close_test();

		open_test("frame_start while busy");
		run_frame(random_frame(), 1'b1, 1'b1);
		close_test();

		open_test("back to back frames");
		run_frame(random_frame(), 1'b0, 1'b0);
		run_frame(random_frame(), 1'b1, 1'b0);
		close_test();

		$display("tests %0d, failed %0d, beats checked %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule
